// ==== rtl/qnt_pkg.sv ====
`default_nettype none

package qnt_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned PIX_W  = 16;  // one pixel, one threshold
  localparam int unsigned DATA_W = 32;  // operands, result, address
  localparam int unsigned LVL_W  = 2;   // tree level counter

  // byte distance from pixel 1's threshold tree to pixel 2's
  localparam int unsigned P2_OFS_4B = 32;  // 15 entries + pad, 2 bytes each
  localparam int unsigned P2_OFS_2B = 8;   // 3 entries + pad

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // quantization mode, same encoding as the vecmode field
  typedef enum logic [2:0] {
    VEC_4B = 3'd0,  // 4-bit level per pixel, 4 compares
    VEC_2B = 3'd1   // 2-bit level per pixel, 2 compares
  } vec_mode_e;

  // control FSM
  typedef enum logic [1:0] {
    IDLE,   // waiting for enable
    FETCH,  // request out, waiting for grant
    WAIT,   // granted, waiting for threshold data
    DONE    // result ready for one cycle
  } qnt_state_e;

endpackage

`default_nettype wire

// ==== rtl/qnt_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,             // start level from ex stage
  input  logic [2:0]                 vecmode_i,            // raw mode field
  input  logic                       request_granted_i,    // memory took the request
  input  logic                       threshold_valid_i,    // threshold data this cycle
  output logic                       threshold_request_o,
  output logic                       ready_o,
  output logic                       start_o,              // one-cycle run start pulse
  output logic                       pix_sel_o,            // 0 pixel 1, 1 pixel 2
  output logic [qnt_pkg::LVL_W-1:0]  level_o,              // current tree level
  output logic                       upd_o,                // compare result is valid
  output qnt_pkg::vec_mode_e         mode_o                // mode held for the run
);

  import qnt_pkg::*;

  qnt_state_e       state_q, state_d;
  vec_mode_e        mode_q;
  logic             pix_sel_q;
  logic [LVL_W-1:0] level_q;
  logic [LVL_W-1:0] last_level;   // deepest level for the captured mode
  logic             last_fetch;   // pixel 2 on the deepest level

  ////////////////////////////////////////////////////////////
  // run bookkeeping
  ////////////////////////////////////////////////////////////

  // 4 compares per pixel in 4-bit mode, 2 in 2-bit mode
  assign last_level = (mode_q == VEC_2B) ? LVL_W'(1) : LVL_W'(3);
  assign last_fetch = pix_sel_q & (level_q == last_level);

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    start_o = 1'b0;
    upd_o   = 1'b0;

    case (state_q)
      IDLE: begin
        if (enable_i) begin
          start_o = 1'b1;   // capture operands this cycle
          state_d = FETCH;
        end
      end

      FETCH: begin
        // request and address held until memory grants
        if (request_granted_i) begin
          state_d = WAIT;
        end
      end

      WAIT: begin
        if (threshold_valid_i) begin
          upd_o = 1'b1;     // compare and step the walk
          if (last_fetch) begin
            state_d = DONE;
          end else begin
            state_d = FETCH;  // other pixel next, or next level
          end
        end
      end

      DONE: begin
        state_d = IDLE;     // result stays in the level registers
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      mode_q    <= VEC_4B;
      pix_sel_q <= 1'b0;
      level_q   <= '0;
    end else begin
      state_q <= state_d;

      if (start_o) begin
        mode_q    <= vec_mode_e'(vecmode_i);  // held for the whole run
        pix_sel_q <= 1'b0;                    // pixel 1 goes first
        level_q   <= '0;
      end else if (upd_o) begin
        pix_sel_q <= ~pix_sel_q;              // alternate pixels every fetch
        if (pix_sel_q) begin
          level_q <= level_q + LVL_W'(1);     // both pixels done on this level
        end
      end
    end
  end

  // outputs
  assign threshold_request_o = (state_q == FETCH);
  assign ready_o             = (state_q == IDLE) | (state_q == DONE);
  assign pix_sel_o           = pix_sel_q;
  assign level_o             = level_q;
  assign mode_o              = mode_q;

endmodule

`default_nettype wire

// ==== rtl/qnt_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_addr_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  logic [qnt_pkg::DATA_W-1:0] op_b_i,               // base, middle of pixel 1 tree
  input  qnt_pkg::vec_mode_e         mode_i,
  input  logic                       pix_sel_i,
  input  logic [qnt_pkg::LVL_W-1:0]  level_i,
  input  logic                       upd_i,
  input  logic                       cmp_bit_i,            // pixel above threshold
  output logic [qnt_pkg::DATA_W-1:0] threshold_address_o
);

  import qnt_pkg::*;

  logic [DATA_W-1:0] addr1_q, addr2_q;  // tree walk positions
  logic [DATA_W-1:0] cur_addr, nxt_addr;
  logic [DATA_W-1:0] step;
  logic [DATA_W-1:0] p2_ofs;

  // step shrinks by half per level, 2-byte entries
  always_comb begin
    step = '0;  // last level, no further fetch
    if (mode_i == VEC_2B) begin
      if (level_i == LVL_W'(0)) step = DATA_W'(2);
    end else begin
      case (level_i)
        LVL_W'(0): step = DATA_W'(8);
        LVL_W'(1): step = DATA_W'(4);
        LVL_W'(2): step = DATA_W'(2);
        default:   step = '0;
      endcase
    end
  end

  // pixel 2 register holds its walk relative to the base, tree offset added on the way out
  assign p2_ofs = (mode_i == VEC_2B) ? DATA_W'(P2_OFS_2B) : DATA_W'(P2_OFS_4B);

  assign cur_addr = pix_sel_i ? addr2_q : addr1_q;
  assign nxt_addr = cmp_bit_i ? (cur_addr + step) : (cur_addr - step);  // up if greater

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      addr1_q <= '0;
      addr2_q <= '0;
    end else if (start_i) begin
      addr1_q <= op_b_i;   // both walks begin at the middle entry
      addr2_q <= op_b_i;
    end else if (upd_i) begin
      if (pix_sel_i) addr2_q <= nxt_addr;
      else           addr1_q <= nxt_addr;
    end
  end

  assign threshold_address_o = pix_sel_i ? (addr2_q + p2_ofs) : addr1_q;

endmodule

`default_nettype wire

// ==== rtl/qnt_level_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_level_acc (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  logic [qnt_pkg::DATA_W-1:0] op_a_i,               // {pixel 2, pixel 1}
  input  logic [qnt_pkg::DATA_W-1:0] threshold_i,          // low half is the threshold
  input  logic                       pix_sel_i,
  input  logic                       upd_i,
  input  qnt_pkg::vec_mode_e         mode_i,
  output logic                       cmp_bit_o,
  output logic [qnt_pkg::DATA_W-1:0] result_o
);

  import qnt_pkg::*;

  localparam int unsigned LB = 2 ** LVL_W;  // one compare bit per tree level

  logic signed [PIX_W-1:0] pix1_q, pix2_q;  // operand copy for the run
  logic signed [PIX_W-1:0] pix_cur;
  logic signed [PIX_W-1:0] thr;
  logic [LB-1:0]           lvl1_q, lvl2_q;  // compare bits, msb first

  // operands only change on start
  always_ff @(posedge clk) begin
    if (start_i) begin
      pix1_q <= op_a_i[PIX_W-1:0];
      pix2_q <= op_a_i[DATA_W-1:PIX_W];
    end
  end

  assign pix_cur   = pix_sel_i ? pix2_q : pix1_q;
  assign thr       = threshold_i[PIX_W-1:0];
  assign cmp_bit_o = (pix_cur > thr);  // signed, equal counts as not greater

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lvl1_q <= '0;
      lvl2_q <= '0;
    end else if (start_i) begin
      lvl1_q <= '0;
      lvl2_q <= '0;
    end else if (upd_i) begin
      if (pix_sel_i) lvl2_q <= {lvl2_q[LB-2:0], cmp_bit_o};
      else           lvl1_q <= {lvl1_q[LB-2:0], cmp_bit_o};
    end
  end

  // pixel 2 above pixel 1, zero-extended
  always_comb begin
    result_o = '0;
    if (mode_i == VEC_2B) begin
      result_o[3:0] = {lvl2_q[1:0], lvl1_q[1:0]};
    end else begin
      result_o[7:0] = {lvl2_q, lvl1_q};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/qnt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_unit (
  input  logic                       clk,
  input  logic                       rst_n,

  // ex stage side
  input  logic                       enable_i,             // start level
  input  logic [2:0]                 vecmode_i,            // 4-bit or 2-bit levels
  input  logic [qnt_pkg::DATA_W-1:0] op_a_i,               // two signed pixels
  input  logic [qnt_pkg::DATA_W-1:0] op_b_i,               // threshold tree base

  // threshold memory side
  input  logic [qnt_pkg::DATA_W-1:0] threshold_i,
  input  logic                       threshold_valid_i,
  input  logic                       request_granted_i,
  output logic                       threshold_request_o,
  output logic [qnt_pkg::DATA_W-1:0] threshold_address_o,

  output logic [qnt_pkg::DATA_W-1:0] result_o,
  output logic                       ready_o
);

  import qnt_pkg::*;

  logic             start;
  logic             pix_sel;
  logic [LVL_W-1:0] level;
  logic             upd;
  vec_mode_e        mode;
  logic             cmp_bit;

  ////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////

  qnt_ctrl u_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .enable_i            (enable_i),
    .vecmode_i           (vecmode_i),
    .request_granted_i   (request_granted_i),
    .threshold_valid_i   (threshold_valid_i),
    .threshold_request_o (threshold_request_o),
    .ready_o             (ready_o),
    .start_o             (start),
    .pix_sel_o           (pix_sel),
    .level_o             (level),
    .upd_o               (upd),
    .mode_o              (mode)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  qnt_addr_gen u_addr_gen (
    .clk                 (clk),
    .rst_n               (rst_n),
    .start_i             (start),
    .op_b_i              (op_b_i),
    .mode_i              (mode),
    .pix_sel_i           (pix_sel),
    .level_i             (level),
    .upd_i               (upd),
    .cmp_bit_i           (cmp_bit),          // direction of the next step
    .threshold_address_o (threshold_address_o)
  );

  qnt_level_acc u_level_acc (
    .clk                 (clk),
    .rst_n               (rst_n),
    .start_i             (start),
    .op_a_i              (op_a_i),
    .threshold_i         (threshold_i),
    .pix_sel_i           (pix_sel),
    .upd_i               (upd),
    .mode_i              (mode),
    .cmp_bit_o           (cmp_bit),
    .result_o            (result_o)
  );

endmodule

`default_nettype wire

// ==== tests/qnt_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_unit_chk (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       enable_i,
  input logic                       granted_i,   // memory grant strobe
  input logic                       req_i,       // threshold request
  input logic [qnt_pkg::DATA_W-1:0] addr_i,      // threshold address
  input logic [qnt_pkg::DATA_W-1:0] result_i,
  input logic                       ready_i
);

  // request held until grant, address must not move
  addr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !granted_i |=> $stable(addr_i))
    else $error("threshold address moved while request was pending");

  req_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(req_i && ready_i))                                 // busy and ready are exclusive
    else $error("request and ready high together");

  // result held from done until the next start
  result_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    ready_i && $past(ready_i) && !enable_i |-> $stable(result_i))
    else $error("result changed while idle");

endmodule

bind qnt_unit qnt_unit_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .enable_i  (enable_i),
  .granted_i (request_granted_i),
  .req_i     (threshold_request_o),
  .addr_i    (threshold_address_o),
  .result_i  (result_o),
  .ready_i   (ready_o)
);

`default_nettype wire

// ==== tests/qnt_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module qnt_unit_tb;

  import qnt_pkg::*;

  localparam int N_OPS   = 16;                          // operations over all tests, rounded up
  localparam int MAX_DLY = 8;                           // grant 3 + valid 3 + 2 base cycles
  localparam int MAX_CYC = N_OPS * 8 * MAX_DLY + 400;   // plus reset and idle gaps

  logic              clk;
  logic              rst_n;
  logic              enable_i;
  logic [2:0]        vecmode_i;
  logic [DATA_W-1:0] op_a_i;
  logic [DATA_W-1:0] op_b_i;
  logic [DATA_W-1:0] threshold_i;
  logic              threshold_valid_i;
  logic              request_granted_i;
  logic              threshold_request_o;
  logic [DATA_W-1:0] threshold_address_o;
  logic [DATA_W-1:0] result_o;
  logic              ready_o;

  logic [PIX_W-1:0] mem [0:1023];   // threshold memory, one halfword per entry
  logic [15:0]      lfsr;
  bit               rand_dly;       // random grant and valid delays
  int               cycles, checks, errors, tests, test_err;

  qnt_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run length guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_bits(input int n, output int v);
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      v = (v << 1) | lfsr[0];
    end
  endtask

  task automatic check_eq(input string sig, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, sig, got, exp);
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    errors += test_err;
    $display("test %s done, %0d errors", name, test_err);
    test_err = 0;
  endtask

  // sorted entries, middle one at base
  task automatic fill_tree(input int base, input int n, input int first, input int stride);
    int k;
    for (k = 0; k < n; k++) begin
      mem[(base + 2 * (k - n / 2)) >> 1] = PIX_W'(first + stride * k);
    end
  endtask

  function automatic int count_above(input logic [PIX_W-1:0] pix, input int n,
                                     input int first, input int stride);
    int k, c;
    c = 0;
    for (k = 0; k < n; k++) begin
      if ($signed(pix) > first + stride * k) c++;   // equal is not above
    end
    return c;
  endfunction

  // one instruction, memory answered here, walk followed by the model
  task automatic run_op(input bit two_bit, input logic [PIX_W-1:0] p1,
                        input logic [PIX_W-1:0] p2, input int base,
                        input logic [DATA_W-1:0] exp_res);
    int                f, n, dly, step;
    logic [DATA_W-1:0] walk [2];
    logic [PIX_W-1:0]  pix, thr;
    n       = two_bit ? 4 : 8;
    walk[0] = base;
    walk[1] = base + (two_bit ? 8 : 32);   // pixel 2 tree above pixel 1
    @(negedge clk);
    enable_i  = 1'b1;
    vecmode_i = two_bit ? 3'd1 : 3'd0;
    op_a_i    = {p2, p1};
    op_b_i    = base;
    @(negedge clk);
    enable_i = 1'b0;
    for (f = 0; f < n; f++) begin
      step = two_bit ? 2 : (8 >> (f / 2));   // 8, 4, 2 per level
      while (!threshold_request_o) @(negedge clk);
      check_eq("threshold_address_o", threshold_address_o, walk[f % 2]);
      dly = 0;
      if (rand_dly) rand_bits(2, dly);
      repeat (dly) @(negedge clk);            // request held without grant
      request_granted_i = 1'b1;
      @(negedge clk);
      request_granted_i = 1'b0;
      if (rand_dly) rand_bits(2, dly);
      repeat (dly) @(negedge clk);
      thr               = mem[walk[f % 2] >> 1];
      threshold_i       = {16'hdead, thr};    // upper half is ignored
      threshold_valid_i = 1'b1;
      @(negedge clk);
      threshold_valid_i = 1'b0;
      pix = (f % 2) ? p2 : p1;
      if ($signed(pix) > $signed(thr)) walk[f % 2] += step;
      else                             walk[f % 2] -= step;
    end
    check_eq("ready_o", ready_o, 1);
    check_eq("result_o", result_o, exp_res);
    repeat (3) begin
      @(negedge clk);
      check_eq("result_o", result_o, exp_res);   // held while idle
    end
  endtask

  task automatic op_4b(input logic [PIX_W-1:0] p1, input logic [PIX_W-1:0] p2);
    int c1, c2;
    c1 = count_above(p1, 15, -700, 100);
    c2 = count_above(p2, 15, -1400, 200);
    run_op(1'b0, p1, p2, 'h100, {24'b0, 4'(c2), 4'(c1)});
  endtask

  task automatic op_2b(input logic [PIX_W-1:0] p1, input logic [PIX_W-1:0] p2);
    int c1, c2;
    c1 = count_above(p1, 3, -10, 10);
    c2 = count_above(p2, 3, 100, 100);
    run_op(1'b1, p1, p2, 'h200, {28'b0, 2'(c2), 2'(c1)});
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic reset_values();
    check_eq("ready_o", ready_o, 1);
    check_eq("threshold_request_o", threshold_request_o, 0);
    check_eq("result_o", result_o, 0);
    finish_test("reset");
  endtask

  task automatic levels_4b();
    op_4b(16'd50, -16'sd1000);
    op_4b(-16'sd650, 16'd1300);
    op_4b(-16'sd1000, 16'd256);
    finish_test("4-bit levels");
  endtask

  task automatic levels_2b();
    op_2b(16'd5, 16'd250);
    op_2b(-16'sd20, 16'd100);
    op_2b(16'd0, 16'd301);
    finish_test("2-bit levels");
  endtask

  task automatic edge_values();
    op_4b(16'd0, 16'd200);              // both equal to a threshold
    op_4b(16'h8000, 16'h7fff);
    op_4b(16'h7fff, 16'h8000);
    finish_test("edge values");
  endtask

  task automatic random_delays();
    rand_dly = 1'b1;
    op_4b(16'd50, -16'sd1000);
    op_4b(-16'sd650, 16'd1300);
    op_4b(-16'sd1000, 16'd256);
    rand_dly = 1'b0;
    finish_test("random delays");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    enable_i = 1'b0;
    vecmode_i = 3'd0;
    op_a_i = '0;
    op_b_i = '0;
    threshold_i = '0;
    threshold_valid_i = 1'b0;
    request_granted_i = 1'b0;
    lfsr = 16'd23;
    rand_dly = 1'b0;
    for (int i = 0; i < 1024; i++) mem[i] = PIX_W'(i * 16'h9e37) ^ 16'h5a5a;
    fill_tree('h100, 15, -700, 100);    // 4-bit trees
    fill_tree('h120, 15, -1400, 200);
    fill_tree('h200, 3, -10, 10);       // 2-bit trees
    fill_tree('h208, 3, 100, 100);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_values();
    levels_4b();
    levels_2b();
    edge_values();
    random_delays();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("Testbench passed");
    else             $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== qnt_unit.f ====
rtl/qnt_pkg.sv
rtl/qnt_ctrl.sv
rtl/qnt_addr_gen.sv
rtl/qnt_level_acc.sv
rtl/qnt_unit.sv
tests/qnt_unit_chk.sv
tests/qnt_unit_tb.sv
